//--- common/tdd_pkg.sv
package tdd_pkg;

  localparam int WORD_W         = 32;
  localparam int ADV_W          = 16;
  localparam int SLOT_W         = 8;
  localparam int SUB_SLOT_W     = 6;
  localparam int SYM_W          = 4;
  localparam int FRAME_NUM_W    = 12;
  localparam int CALIB_PERIOD_W = 8;

  typedef logic [WORD_W-1:0]         word_t;
  typedef logic [ADV_W-1:0]          adv_t;
  typedef logic [SLOT_W-1:0]         slot_t;
  typedef logic [SUB_SLOT_W-1:0]     sub_slot_t;
  typedef logic [SYM_W-1:0]          sym_t;
  typedef logic [FRAME_NUM_W-1:0]    frame_num_t;
  typedef logic [CALIB_PERIOD_W-1:0] calib_period_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    CLEAR = 2'd1,
    LAST  = 2'd2
  } rf_state_t;

  // tddc_ctrl bits
  localparam int CTRL_GPIO_SEL = 0;
  localparam int CTRL_ENABLE   = 1;
  localparam int CTRL_RESET    = 2;
  localparam int CTRL_PPS_DIS  = 3;

  // refresh request bit in state_time_cal
  localparam int STC_REQ = 0;

  // frame_comprise fields
  localparam int FC_TDD_SLOT_HI = 31;
  localparam int FC_TDD_SLOT_LO = 24;
  localparam int FC_DL_SLOT_HI  = 23;
  localparam int FC_DL_SLOT_LO  = 18;
  localparam int FC_UL_SLOT_HI  = 17;
  localparam int FC_UL_SLOT_LO  = 12;
  localparam int FC_SDL_SYM_HI  = 11;
  localparam int FC_SDL_SYM_LO  = 8;
  localparam int FC_GAP_SYM_HI  = 7;
  localparam int FC_GAP_SYM_LO  = 4;
  localparam int FC_SUL_SYM_HI  = 3;
  localparam int FC_SUL_SYM_LO  = 0;

  // air_num fields
  localparam int AIR_SYM_HI   = 23;
  localparam int AIR_SYM_LO   = 20;
  localparam int AIR_SLOT_HI  = 19;
  localparam int AIR_SLOT_LO  = 12;
  localparam int AIR_FRAME_HI = 11;
  localparam int AIR_FRAME_LO = 0;

  // output_active fields
  localparam int OA_CALIB_NUM_HI    = 3;
  localparam int OA_CALIB_NUM_LO    = 0;
  localparam int OA_CALIB_PERIOD_HI = 15;
  localparam int OA_CALIB_PERIOD_LO = 8;

endpackage

//--- frame_timing/tdd_calib_trigger.sv
`timescale 1ns/1ps

module tdd_calib_trigger (
  input  logic           clk,
  input  logic           tdd_rst_n,
  input  logic           pps_edge,
  input  logic           t_start,
  input  tdd_pkg::word_t output_active,
  output logic           calib_trig
);

  import tdd_pkg::*;

  calib_period_t calib_period;
  calib_period_t calib_cnt;

  assign calib_period = output_active[OA_CALIB_PERIOD_HI:OA_CALIB_PERIOD_LO];

  // pps periods modulo the calibration period
  always_ff @(posedge clk or negedge tdd_rst_n) begin
    if (!tdd_rst_n) begin
      calib_cnt <= '0;
    end else if (pps_edge) begin
      calib_cnt <= (calib_cnt == calib_period - 8'd1) ? '0 : calib_cnt + 8'd1;
    end
  end

  // fires after the frame start of period 1
  always_ff @(posedge clk or negedge tdd_rst_n) begin
    if (!tdd_rst_n) begin
      calib_trig <= 1'b0;
    end else begin
      calib_trig <= t_start && (calib_cnt == 8'd1);
    end
  end

endmodule

//--- frame_timing/tdd_frame_timer.sv
`timescale 1ns/1ps

module tdd_frame_timer (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           tdd_rst_n,
  input  logic           pps_in,
  input  logic           sync_pps_disable,
  input  tdd_pkg::word_t frame_time,
  input  tdd_pkg::word_t rx_advance,
  input  tdd_pkg::word_t rx_delay,
  input  tdd_pkg::word_t tx_advance,
  input  tdd_pkg::word_t tx_delay,
  output logic           pps_edge,
  output logic           t_start,
  output logic           frame_end
);

  import tdd_pkg::*;

  typedef enum logic {
    ST_IDLE  = 1'b0,
    ST_COUNT = 1'b1
  } st_state_t;

  st_state_t st_state;
  logic      pps_in_r;
  logic      start_enable;
  word_t     rel_time;
  word_t     start_delay;
  word_t     start_cnt;
  word_t     frame_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pps_in_r <= 1'b0;
    end else begin
      pps_in_r <= pps_in;
    end
  end

  assign pps_edge = pps_in & ~pps_in_r;

  // frame start sits ahead of the PPS by the net rx/tx advance
  assign rel_time    = (rx_advance - rx_delay) + (tx_advance - tx_delay);
  assign start_delay = frame_time - rel_time;

  always_ff @(posedge clk or negedge tdd_rst_n) begin
    if (!tdd_rst_n) begin
      st_state     <= ST_IDLE;
      start_cnt    <= '0;
      start_enable <= 1'b0;
      t_start      <= 1'b0;
    end else begin
      t_start <= 1'b0;
      case (st_state)
        ST_IDLE: begin
          if (pps_edge) begin
            start_cnt <= start_delay;
            st_state  <= ST_COUNT;
          end
        end
        ST_COUNT: begin
          if (start_cnt == 32'd1) begin
            t_start      <= 1'b1;
            start_enable <= 1'b1;
            st_state     <= ST_IDLE;
          end else begin
            start_cnt <= start_cnt - 32'd1;
          end
        end
        default: st_state <= ST_IDLE;
      endcase
    end
  end

  // frame counter, realigned on every frame start unless PPS is ignored
  always_ff @(posedge clk or negedge tdd_rst_n) begin
    if (!tdd_rst_n) begin
      frame_cnt <= '0;
    end else if (t_start && !sync_pps_disable) begin
      frame_cnt <= '0;
    end else if (start_enable) begin
      frame_cnt <= frame_end ? '0 : frame_cnt + 32'd1;
    end else begin
      frame_cnt <= '0;
    end
  end

  assign frame_end = (frame_cnt == frame_time - 32'd1);

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module tb_tdd_regist_ctrl -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^=== PASS ===$" && echo "run passed" || { echo "run failed"; exit 1; }

//--- tests/tb_tdd_regist_ctrl.sv
`timescale 1ns/1ps

module tb_tdd_regist_ctrl;

  import tdd_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_TESTS    = 3;
  localparam int REC_W        = 11;
  localparam int RESET_BUDGET = 16;

  localparam word_t CTRL_ON  = word_t'((1 << CTRL_ENABLE) | (1 << CTRL_GPIO_SEL));
  localparam word_t CTRL_ALL = word_t'((1 << CTRL_ENABLE) | (1 << CTRL_GPIO_SEL) |
                                       (1 << CTRL_RESET) | (1 << CTRL_PPS_DIS));

  logic       clk;
  logic       rst_n;
  logic       pps_in;
  logic       state_done;
  word_t      tddc_ctrl, state_time_cal, frame_comprise, frame_time, output_active, air_num;
  word_t      rx_advance, rx_delay, tx_advance, tx_delay;
  logic       state_rst_n, t_start, calib_trig, dout_refresh_trig, refresh_busy;
  logic       sync_pps_disable, gpio_ctrl_sel;
  slot_t      dout_tdd_slot, dout_slot_num;
  sub_slot_t  dout_dl_slot, dout_ul_slot;
  sym_t       dout_sdl_symbol, dout_gap_symbol, dout_sul_symbol, dout_calib_num;
  sym_t       dout_symbol_num;
  frame_num_t dout_frame_num;
  adv_t       dout_rx_advance, dout_rx_delay, dout_tx_advance, dout_tx_delay;

  word_t  tdata [0:NUM_TESTS*REC_W-1];
  integer seed;
  int     errors;
  int     n_pass;
  int     n_fail;
  int     limit_ns;

  tdd_regist_ctrl UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // one clock from falling edge to falling edge
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk);
      @(negedge clk);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_slot(input string name, input slot_t exp, input slot_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_sub_slot(input string name, input sub_slot_t exp, input sub_slot_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_sym(input string name, input sym_t exp, input sym_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_adv(input string name, input adv_t exp, input adv_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_frame(input string name, input frame_num_t exp, input frame_num_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  // every snapshot output against its slice of the source words
  task automatic check_fields(input word_t fc, input word_t oa, input word_t air,
                              input word_t rxa, input word_t rxd,
                              input word_t txa, input word_t txd);
    check_slot("dout_tdd_slot", fc[FC_TDD_SLOT_HI:FC_TDD_SLOT_LO], dout_tdd_slot);
    check_sub_slot("dout_dl_slot", fc[FC_DL_SLOT_HI:FC_DL_SLOT_LO], dout_dl_slot);
    check_sub_slot("dout_ul_slot", fc[FC_UL_SLOT_HI:FC_UL_SLOT_LO], dout_ul_slot);
    check_sym("dout_sdl_symbol", fc[FC_SDL_SYM_HI:FC_SDL_SYM_LO], dout_sdl_symbol);
    check_sym("dout_gap_symbol", fc[FC_GAP_SYM_HI:FC_GAP_SYM_LO], dout_gap_symbol);
    check_sym("dout_sul_symbol", fc[FC_SUL_SYM_HI:FC_SUL_SYM_LO], dout_sul_symbol);
    check_sym("dout_calib_num", oa[OA_CALIB_NUM_HI:OA_CALIB_NUM_LO], dout_calib_num);
    check_sym("dout_symbol_num", air[AIR_SYM_HI:AIR_SYM_LO], dout_symbol_num);
    check_slot("dout_slot_num", air[AIR_SLOT_HI:AIR_SLOT_LO], dout_slot_num);
    check_frame("dout_frame_num", air[AIR_FRAME_HI:AIR_FRAME_LO], dout_frame_num);
    check_adv("dout_rx_advance", rxa[ADV_W-1:0], dout_rx_advance);
    check_adv("dout_rx_delay", rxd[ADV_W-1:0], dout_rx_delay);
    check_adv("dout_tx_advance", txa[ADV_W-1:0], dout_tx_advance);
    check_adv("dout_tx_delay", txd[ADV_W-1:0], dout_tx_delay);
  endtask

  task automatic check_idle_outputs();
    check_bit("t_start", 1'b0, t_start);
    check_bit("calib_trig", 1'b0, calib_trig);
    check_bit("dout_refresh_trig", 1'b0, dout_refresh_trig);
    check_bit("refresh_busy", 1'b0, refresh_busy);
    check_bit("state_rst_n", 1'b0, state_rst_n);
    check_fields('0, '0, '0, '0, '0, '0, '0);
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      n_pass++;
      $display("test %s: passed", name);
    end else begin
      n_fail++;
      $display("test %s: failed with %0d errors", name, errors - err0);
    end
  endtask

  // one PPS pulse with t_start D+1 edges later and calib_trig right after it
  task automatic pps_pulse(input word_t d, input logic exp_calib);
    pps_in = 1'b1;
    for (int n = 1; n <= int'(d) + 1; n++) begin
      tick(1);
      pps_in = 1'b0;
      check_bit("t_start", n == int'(d) + 1, t_start);
      check_bit("calib_trig", 1'b0, calib_trig);
    end
    tick(1);
    check_bit("t_start", 1'b0, t_start);
    check_bit("calib_trig", exp_calib, calib_trig);
    repeat (3) begin
      tick(1);
      check_bit("t_start", 1'b0, t_start);
      check_bit("calib_trig", 1'b0, calib_trig);
    end
  endtask

  task automatic run_test(input int t);
    int            base;
    int            err0;
    int            npps;
    int            wait_n;
    int            limit;
    int            n;
    logic          seen;
    word_t         d_calc;
    word_t         d_exp;
    calib_period_t period;
    base   = t * REC_W;
    err0   = errors;
    d_exp  = tdata[base + 8];
    npps   = tdata[base + 9];
    period = tdata[base + 2][OA_CALIB_PERIOD_HI:OA_CALIB_PERIOD_LO];

    // block disabled while the configuration is applied
    @(negedge clk);
    tddc_ctrl      = '0;
    frame_comprise = tdata[base + 0];
    frame_time     = tdata[base + 1];
    output_active  = tdata[base + 2];
    air_num        = tdata[base + 3];
    rx_advance     = tdata[base + 4];
    rx_delay       = tdata[base + 5];
    tx_advance     = tdata[base + 6];
    tx_delay       = tdata[base + 7];
    tick(3);
    check_bit("gpio_ctrl_sel", 1'b0, gpio_ctrl_sel);
    check_bit("state_rst_n", 1'b0, state_rst_n);
    d_calc = frame_time - ((rx_advance - rx_delay) + (tx_advance - tx_delay));
    if (d_calc !== d_exp) begin
      $display("test %0d: start delay %0d from the words differs from %0d in the data file",
               t + 1, d_calc, d_exp);
      errors++;
    end

    // enable then two sync flops, the edge flop and the load
    tddc_ctrl = CTRL_ON;
    tick(1);
    check_bit("gpio_ctrl_sel", 1'b0, gpio_ctrl_sel);
    tick(1);
    check_bit("gpio_ctrl_sel", 1'b1, gpio_ctrl_sel);
    check_bit("sync_pps_disable", 1'b0, sync_pps_disable);
    tick(2);
    check_fields(tdata[base], tdata[base + 2], tdata[base + 3], tdata[base + 4],
                 tdata[base + 5], tdata[base + 6], tdata[base + 7]);
    frame_comprise = ~frame_comprise;
    air_num        = ~air_num;
    tick(3);
    check_fields(tdata[base], tdata[base + 2], tdata[base + 3], tdata[base + 4],
                 tdata[base + 5], tdata[base + 6], tdata[base + 7]);
    frame_comprise = tdata[base + 0];
    air_num        = tdata[base + 3];

    for (int k = 0; k < npps; k++) begin
      pps_pulse(d_exp, (k % int'(period)) == 0);
    end

    // refresh with fresh words
    frame_comprise = $random(seed);
    air_num        = $random(seed);
    rx_advance     = $random(seed);
    rx_delay       = $random(seed);
    tx_advance     = $random(seed);
    tx_delay       = $random(seed);
    output_active[OA_CALIB_NUM_HI:OA_CALIB_NUM_LO] = sym_t'($random(seed));
    state_time_cal = word_t'(1 << STC_REQ);
    tick(1);
    check_bit("refresh_busy", 1'b1, refresh_busy);
    state_time_cal = '0;
    wait_n = 1 + int'({$random(seed)} % 8);
    tick(wait_n);
    state_done = 1'b1;
    tick(1);
    state_done = 1'b0;
    check_bit("state_rst_n", 1'b0, state_rst_n);
    limit = int'(frame_time) + 4;
    n     = 0;
    seen  = 1'b0;
    while (!seen && n < limit) begin
      tick(1);
      n++;
      if (dout_refresh_trig) begin
        seen = 1'b1;
      end else begin
        check_bit("state_rst_n", 1'b0, state_rst_n);
        check_bit("refresh_busy", 1'b1, refresh_busy);
      end
    end
    if (!seen) begin
      $display("test %0d: no refresh trigger within %0d cycles of state_done", t + 1, limit);
      errors++;
    end else begin
      check_bit("refresh_busy", 1'b0, refresh_busy);
      check_bit("state_rst_n", 1'b1, state_rst_n);
    end
    tick(1);
    check_bit("dout_refresh_trig", 1'b0, dout_refresh_trig);
    check_fields(frame_comprise, output_active, air_num, rx_advance, rx_delay,
                 tx_advance, tx_delay);

    // all control bits reach the outputs after two flops
    tddc_ctrl = CTRL_ALL;
    tick(1);
    check_bit("sync_pps_disable", 1'b0, sync_pps_disable);
    tick(1);
    check_bit("sync_pps_disable", 1'b1, sync_pps_disable);
    check_bit("gpio_ctrl_sel", 1'b1, gpio_ctrl_sel);
    check_bit("state_rst_n", 1'b0, state_rst_n);
    report_test($sformatf("%0d", t + 1), err0);
  endtask

  function automatic int budget_total();
    int sum;
    sum = RESET_BUDGET;
    for (int t = 0; t < NUM_TESTS; t++) begin
      sum += int'(tdata[t * REC_W + 10]);
    end
    return sum;
  endfunction

  // watchdog sized from the budgets in the data file
  initial begin
    #1;
    limit_ns = 2 * budget_total() * CLK_PERIOD;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    seed           = 88;
    errors         = 0;
    n_pass         = 0;
    n_fail         = 0;
    rst_n          = 1'b0;
    pps_in         = 1'b0;
    state_done     = 1'b0;
    tddc_ctrl      = '0;
    state_time_cal = '0;
    frame_comprise = '0;
    frame_time     = '0;
    output_active  = '0;
    air_num        = '0;
    rx_advance     = '0;
    rx_delay       = '0;
    tx_advance     = '0;
    tx_delay       = '0;
    $readmemh("tests/tdd_testdata.txt", tdata);

    repeat (8) @(posedge clk);
    @(negedge clk);
    check_idle_outputs();
    rst_n = 1'b1;
    tick(1);
    check_idle_outputs();
    report_test("reset", 0);

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end

    $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- tests/tdd_testdata.txt
// one test per line, eleven hex words:
// frame_comprise frame_time output_active air_num rx_advance rx_delay tx_advance tx_delay
// expected_start_delay pps_pulses cycle_budget
A5E4C321 00000020 00000205 00ABC123 00000008 00000002 00000006 00000003 00000017 00000004 00000100
12345678 00000010 0000030A 00F5A9FF 00000003 00000001 00000002 00000001 0000000D 00000005 00000100
FFFFFFFF 00000040 0000040F 00FFFFFF 00050010 00050004 0003000C 00030008 00000030 00000005 00000200

//--- verilog/tdd_ctrl_sync.sv
`timescale 1ns/1ps

module tdd_ctrl_sync (
  input  logic          clk,
  input  logic          rst_n,
  input  tdd_pkg::word_t tddc_ctrl,
  output logic          sync_pps_disable,
  output logic          gpio_ctrl_sel,
  output logic          enable_start,
  output logic          tdd_rst_n
);

  import tdd_pkg::*;

  word_t ctrl_r0;
  word_t ctrl_r1;
  logic  enable_sync;
  logic  enable_d;

  // two flop stages on the host word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_r0 <= '0;
      ctrl_r1 <= '0;
    end else begin
      ctrl_r0 <= tddc_ctrl;
      ctrl_r1 <= ctrl_r0;
    end
  end

  assign sync_pps_disable = ctrl_r1[CTRL_PPS_DIS];
  assign gpio_ctrl_sel    = ctrl_r1[CTRL_GPIO_SEL];
  assign enable_sync      = ctrl_r1[CTRL_ENABLE];

  // registered strobe on rising enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_d     <= 1'b0;
      enable_start <= 1'b0;
    end else begin
      enable_d     <= enable_sync;
      enable_start <= enable_sync & ~enable_d;
    end
  end

  // block held in reset unless enabled and gpio selected
  assign tdd_rst_n = rst_n & ~ctrl_r1[CTRL_RESET] & enable_sync & gpio_ctrl_sel;

endmodule

//--- verilog/tdd_refresh_seq.sv
`timescale 1ns/1ps

module tdd_refresh_seq (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           tdd_rst_n,
  input  logic           state_done,
  input  logic           frame_end,
  input  tdd_pkg::word_t state_time_cal,
  output logic           refresh_busy,
  output logic           refresh_hold,
  output logic           dout_refresh_trig,
  output logic           state_rst_n
);

  import tdd_pkg::*;

  rf_state_t rf_state;
  logic      req;
  logic      req_r;
  logic      req_edge;

  // host sets the request bit
  assign req = state_time_cal[STC_REQ];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_r <= 1'b0;
    end else begin
      req_r <= req;
    end
  end

  assign req_edge = req & ~req_r;

  always_ff @(posedge clk or negedge tdd_rst_n) begin
    if (!tdd_rst_n) begin
      rf_state          <= IDLE;
      refresh_busy      <= 1'b0;
      refresh_hold      <= 1'b0;
      dout_refresh_trig <= 1'b0;
    end else begin
      dout_refresh_trig <= 1'b0;
      case (rf_state)
        IDLE: begin
          if (req_edge) begin
            refresh_busy <= 1'b1;
            rf_state     <= CLEAR;
          end
        end
        // wait for downstream FSMs to report done
        CLEAR: begin
          if (state_done) begin
            refresh_hold <= 1'b1;
            rf_state     <= LAST;
          end
        end
        // release on the frame boundary
        LAST: begin
          if (frame_end) begin
            dout_refresh_trig <= 1'b1;
            refresh_hold      <= 1'b0;
            refresh_busy      <= 1'b0;
            rf_state          <= IDLE;
          end
        end
        default: rf_state <= IDLE;
      endcase
    end
  end

  assign state_rst_n = tdd_rst_n & ~refresh_hold;

endmodule

//--- verilog/tdd_reg_snapshot.sv
`timescale 1ns/1ps

module tdd_reg_snapshot (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_start,
  input  logic                 refresh_hold,
  input  tdd_pkg::word_t       frame_comprise,
  input  tdd_pkg::word_t       output_active,
  input  tdd_pkg::word_t       air_num,
  input  tdd_pkg::word_t       rx_advance,
  input  tdd_pkg::word_t       rx_delay,
  input  tdd_pkg::word_t       tx_advance,
  input  tdd_pkg::word_t       tx_delay,
  output tdd_pkg::slot_t       dout_tdd_slot,
  output tdd_pkg::sub_slot_t   dout_dl_slot,
  output tdd_pkg::sub_slot_t   dout_ul_slot,
  output tdd_pkg::sym_t        dout_sdl_symbol,
  output tdd_pkg::sym_t        dout_gap_symbol,
  output tdd_pkg::sym_t        dout_sul_symbol,
  output tdd_pkg::sym_t        dout_calib_num,
  output tdd_pkg::sym_t        dout_symbol_num,
  output tdd_pkg::slot_t       dout_slot_num,
  output tdd_pkg::frame_num_t  dout_frame_num,
  output tdd_pkg::adv_t        dout_rx_advance,
  output tdd_pkg::adv_t        dout_rx_delay,
  output tdd_pkg::adv_t        dout_tx_advance,
  output tdd_pkg::adv_t        dout_tx_delay
);

  import tdd_pkg::*;

  logic load;

  assign load = enable_start | refresh_hold;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout_tdd_slot   <= '0;
      dout_dl_slot    <= '0;
      dout_ul_slot    <= '0;
      dout_sdl_symbol <= '0;
      dout_gap_symbol <= '0;
      dout_sul_symbol <= '0;
      dout_calib_num  <= '0;
      dout_symbol_num <= '0;
      dout_slot_num   <= '0;
      dout_frame_num  <= '0;
      dout_rx_advance <= '0;
      dout_rx_delay   <= '0;
      dout_tx_advance <= '0;
      dout_tx_delay   <= '0;
    end else if (load) begin
      // frame format
      dout_tdd_slot   <= frame_comprise[FC_TDD_SLOT_HI:FC_TDD_SLOT_LO];
      dout_dl_slot    <= frame_comprise[FC_DL_SLOT_HI:FC_DL_SLOT_LO];
      dout_ul_slot    <= frame_comprise[FC_UL_SLOT_HI:FC_UL_SLOT_LO];
      dout_sdl_symbol <= frame_comprise[FC_SDL_SYM_HI:FC_SDL_SYM_LO];
      dout_gap_symbol <= frame_comprise[FC_GAP_SYM_HI:FC_GAP_SYM_LO];
      dout_sul_symbol <= frame_comprise[FC_SUL_SYM_HI:FC_SUL_SYM_LO];
      dout_calib_num  <= output_active[OA_CALIB_NUM_HI:OA_CALIB_NUM_LO];
      // air interface position
      dout_symbol_num <= air_num[AIR_SYM_HI:AIR_SYM_LO];
      dout_slot_num   <= air_num[AIR_SLOT_HI:AIR_SLOT_LO];
      dout_frame_num  <= air_num[AIR_FRAME_HI:AIR_FRAME_LO];
      // low half of the timing words
      dout_rx_advance <= rx_advance[ADV_W-1:0];
      dout_rx_delay   <= rx_delay[ADV_W-1:0];
      dout_tx_advance <= tx_advance[ADV_W-1:0];
      dout_tx_delay   <= tx_delay[ADV_W-1:0];
    end
  end

endmodule

//--- verilog/tdd_regist_ctrl.sv
`timescale 1ns/1ps

module tdd_regist_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pps_in,
  input  logic                state_done,
  input  tdd_pkg::word_t      tddc_ctrl,
  input  tdd_pkg::word_t      state_time_cal,
  input  tdd_pkg::word_t      frame_comprise,
  input  tdd_pkg::word_t      frame_time,
  input  tdd_pkg::word_t      output_active,
  input  tdd_pkg::word_t      air_num,
  input  tdd_pkg::word_t      rx_advance,
  input  tdd_pkg::word_t      rx_delay,
  input  tdd_pkg::word_t      tx_advance,
  input  tdd_pkg::word_t      tx_delay,
  output logic                state_rst_n,
  output logic                t_start,
  output logic                calib_trig,
  output logic                dout_refresh_trig,
  output logic                refresh_busy,
  output logic                sync_pps_disable,
  output logic                gpio_ctrl_sel,
  output tdd_pkg::slot_t      dout_tdd_slot,
  output tdd_pkg::sub_slot_t  dout_dl_slot,
  output tdd_pkg::sub_slot_t  dout_ul_slot,
  output tdd_pkg::sym_t       dout_sdl_symbol,
  output tdd_pkg::sym_t       dout_gap_symbol,
  output tdd_pkg::sym_t       dout_sul_symbol,
  output tdd_pkg::sym_t       dout_calib_num,
  output tdd_pkg::sym_t       dout_symbol_num,
  output tdd_pkg::slot_t      dout_slot_num,
  output tdd_pkg::frame_num_t dout_frame_num,
  output tdd_pkg::adv_t       dout_rx_advance,
  output tdd_pkg::adv_t       dout_rx_delay,
  output tdd_pkg::adv_t       dout_tx_advance,
  output tdd_pkg::adv_t       dout_tx_delay
);

  logic enable_start;
  logic tdd_rst_n;
  logic pps_edge;
  logic frame_end;
  logic refresh_hold;

  tdd_ctrl_sync u_ctrl_sync (
    .clk              (clk),
    .rst_n            (rst_n),
    .tddc_ctrl        (tddc_ctrl),
    .sync_pps_disable (sync_pps_disable),
    .gpio_ctrl_sel    (gpio_ctrl_sel),
    .enable_start     (enable_start),
    .tdd_rst_n        (tdd_rst_n)
  );

  tdd_frame_timer u_frame_timer (
    .clk              (clk),
    .rst_n            (rst_n),
    .tdd_rst_n        (tdd_rst_n),
    .pps_in           (pps_in),
    .sync_pps_disable (sync_pps_disable),
    .frame_time       (frame_time),
    .rx_advance       (rx_advance),
    .rx_delay         (rx_delay),
    .tx_advance       (tx_advance),
    .tx_delay         (tx_delay),
    .pps_edge         (pps_edge),
    .t_start          (t_start),
    .frame_end        (frame_end)
  );

  tdd_calib_trigger u_calib_trigger (
    .clk           (clk),
    .tdd_rst_n     (tdd_rst_n),
    .pps_edge      (pps_edge),
    .t_start       (t_start),
    .output_active (output_active),
    .calib_trig    (calib_trig)
  );

  tdd_refresh_seq u_refresh_seq (
    .clk               (clk),
    .rst_n             (rst_n),
    .tdd_rst_n         (tdd_rst_n),
    .state_done        (state_done),
    .frame_end         (frame_end),
    .state_time_cal    (state_time_cal),
    .refresh_busy      (refresh_busy),
    .refresh_hold      (refresh_hold),
    .dout_refresh_trig (dout_refresh_trig),
    .state_rst_n       (state_rst_n)
  );

  tdd_reg_snapshot u_reg_snapshot (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_start    (enable_start),
    .refresh_hold    (refresh_hold),
    .frame_comprise  (frame_comprise),
    .output_active   (output_active),
    .air_num         (air_num),
    .rx_advance      (rx_advance),
    .rx_delay        (rx_delay),
    .tx_advance      (tx_advance),
    .tx_delay        (tx_delay),
    .dout_tdd_slot   (dout_tdd_slot),
    .dout_dl_slot    (dout_dl_slot),
    .dout_ul_slot    (dout_ul_slot),
    .dout_sdl_symbol (dout_sdl_symbol),
    .dout_gap_symbol (dout_gap_symbol),
    .dout_sul_symbol (dout_sul_symbol),
    .dout_calib_num  (dout_calib_num),
    .dout_symbol_num (dout_symbol_num),
    .dout_slot_num   (dout_slot_num),
    .dout_frame_num  (dout_frame_num),
    .dout_rx_advance (dout_rx_advance),
    .dout_rx_delay   (dout_rx_delay),
    .dout_tx_advance (dout_tx_advance),
    .dout_tx_delay   (dout_tx_delay)
  );

endmodule

//--- vlog.f
common/tdd_pkg.sv
verilog/tdd_ctrl_sync.sv
frame_timing/tdd_frame_timer.sv
frame_timing/tdd_calib_trigger.sv
verilog/tdd_refresh_seq.sv
verilog/tdd_reg_snapshot.sv
verilog/tdd_regist_ctrl.sv
tests/tb_tdd_regist_ctrl.sv
